//--- verilog/riscv_isa_pkg.sv
package riscv_isa_pkg;

    // ========================================
    // Widths
    // ========================================

    localparam int XLEN       = 32;       // Data and address width
    localparam int REG_ADDR_W = 5;        // Register index width

    // ========================================
    // Opcodes and formats
    // ========================================

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,           // Load upper immediate
        OP_AUIPC  = 7'b0010111,           // Upper immediate plus PC
        OP_JAL    = 7'b1101111,           // Jump and link
        OP_JALR   = 7'b1100111,           // Jump and link register
        OP_BRANCH = 7'b1100011,           // Conditional branches
        OP_LOAD   = 7'b0000011,           // Loads
        OP_STORE  = 7'b0100011,           // Stores
        OP_IMM    = 7'b0010011,           // Register-immediate ALU
        OP_REG    = 7'b0110011            // Register-register ALU
    } opcode_t;

    typedef enum logic [2:0] {
        FMT_R = 3'b000,                   // No immediate
        FMT_I = 3'b001,                   // 12-bit, bits 31:20
        FMT_S = 3'b010,                   // 12-bit, split around rd slot
        FMT_B = 3'b011,                   // 13-bit branch offset
        FMT_U = 3'b100,                   // Upper 20 bits
        FMT_J = 3'b101                    // 21-bit jump offset
    } instr_fmt_t;

    // ========================================
    // Instruction word views
    // ========================================

    // Register view, used for control and register addressing
    typedef struct packed {
        logic [6:0]            funct7;    // Bits 31:25
        logic [REG_ADDR_W-1:0] rs2;       // Bits 24:20
        logic [REG_ADDR_W-1:0] rs1;       // Bits 19:15
        logic [2:0]            funct3;    // Bits 14:12
        logic [REG_ADDR_W-1:0] rd;        // Bits 11:7
        logic [6:0]            opcode;    // Bits 6:0
    } r_fields_t;

    // Same bits cut at every immediate boundary of I/S/B/U/J
    typedef struct packed {
        logic       sign;                 // Bit 31, sign of every format
        logic [5:0] b30_25;               // Shared by I/S/B/U/J
        logic [3:0] b24_21;               // I, U and J
        logic       b20;                  // I lsb, U, J bit 11
        logic [7:0] b19_12;               // U and J
        logic [3:0] b11_8;                // S and B
        logic       b7;                   // S lsb, B bit 11
        logic [6:0] opcode;               // Bits 6:0
    } imm_fields_t;

    // One instruction word, decoded two ways
    typedef union packed {
        r_fields_t   r_view;              // Register fields
        imm_fields_t imm_view;            // Immediate pieces
    } instr_word_u;

endpackage

//--- verilog/decode_pkg.sv
package decode_pkg;

    // ========================================
    // ALU and memory encodings
    // ========================================

    // Codes shared with the execute-stage ALU
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,               // a + b
        ALU_SUB  = 4'b0001,               // a - b
        ALU_AND  = 4'b0010,               // a & b
        ALU_OR   = 4'b0011,               // a | b
        ALU_XOR  = 4'b0100,               // a ^ b
        ALU_SLT  = 4'b0101,               // Signed compare
        ALU_SLTU = 4'b0110,               // Unsigned compare
        ALU_SLL  = 4'b0111,               // Shift left
        ALU_SRL  = 4'b1000,               // Shift right logical
        ALU_SRA  = 4'b1001,               // Shift right arithmetic
        ALU_LUI  = 4'b1010,               // Pass operand b
        ALU_COPY = 4'b1011                // Pass operand a
    } alu_op_t;

    // Access size, same code as load/store funct3
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,                  // Byte, signed
        MEM_H  = 3'b001,                  // Half, signed
        MEM_W  = 3'b010,                  // Word
        MEM_BU = 3'b100,                  // Byte, unsigned
        MEM_HU = 3'b101                   // Half, unsigned
    } mem_size_t;

    // ========================================
    // Stage bundles
    // ========================================

    typedef struct packed {
        alu_op_t    alu_op;               // ALU function
        logic       alu_src;              // 1 = immediate as operand b
        logic       reg_write;            // Writes rd
        logic       mem_read;             // Load
        logic       mem_write;            // Store
        mem_size_t  mem_size;             // Load/store width
        logic       branch;               // Conditional branch
        logic       jump;                 // JAL or JALR
        logic [2:0] branch_type;          // Branch funct3
    } ctrl_t;

    // What execute sees from decode
    typedef struct packed {
        logic                              valid;     // Fetch valid, carried along
        logic [riscv_isa_pkg::XLEN-1:0]    pc;        // Instruction address
        logic [riscv_isa_pkg::REG_ADDR_W-1:0] rd;     // Destination register
        logic [riscv_isa_pkg::XLEN-1:0]    rs1_data;  // Operand a from regfile
        logic [riscv_isa_pkg::XLEN-1:0]    rs2_data;  // Operand b from regfile
        logic [riscv_isa_pkg::XLEN-1:0]    imm;       // Sign-extended immediate
        ctrl_t                             ctrl;      // Control bundle
    } dec_out_t;

endpackage

//--- verilog/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  riscv_isa_pkg::instr_word_u          instr_i,   // Raw instruction word
    output logic [riscv_isa_pkg::XLEN-1:0]      imm_o      // Sign-extended immediate
);

    import riscv_isa_pkg::*;

    instr_fmt_t  fmt;                     // Detected format
    imm_fields_t f;                       // Immediate view of the word

    assign f = instr_i.imm_view;

    // ========================================
    // Format detection
    // ========================================

    always_comb begin
        case (f.opcode)
            OP_LUI, OP_AUIPC: fmt = FMT_U;
            OP_JAL:           fmt = FMT_J;
            OP_BRANCH:        fmt = FMT_B;
            OP_STORE:         fmt = FMT_S;
            OP_REG:           fmt = FMT_R;
            default:          fmt = FMT_I;  // JALR, loads, OP-IMM, unknown
        endcase
    end

    // ========================================
    // Immediate assembly
    // ========================================

    always_comb begin
        case (fmt)
            FMT_I: begin
                imm_o = {{21{f.sign}}, f.b30_25, f.b24_21, f.b20};           // imm[11:0]
            end
            FMT_S: begin
                imm_o = {{21{f.sign}}, f.b30_25, f.b11_8, f.b7};             // imm[11:0]
            end
            FMT_B: begin
                // Bit 7 lands at imm[11], lsb always zero
                imm_o = {{20{f.sign}}, f.b7, f.b30_25, f.b11_8, 1'b0};
            end
            FMT_U: begin
                imm_o = {f.sign, f.b30_25, f.b24_21, f.b20, f.b19_12, 12'h000};
            end
            FMT_J: begin
                // imm[20|10:1|11|19:12] reordered to natural order
                imm_o = {{12{f.sign}}, f.b19_12, f.b20, f.b30_25, f.b24_21, 1'b0};
            end
            default: begin
                imm_o = '0;                   // R-type has none
            end
        endcase
    end

endmodule

//--- verilog/ctrl_decoder.sv
`timescale 1ns/1ps

module ctrl_decoder (
    input  riscv_isa_pkg::instr_word_u instr_i,   // Raw instruction word
    output decode_pkg::ctrl_t          ctrl_o     // Control for execute/memory
);

    import riscv_isa_pkg::*;
    import decode_pkg::*;

    logic [6:0] opcode;                   // Major opcode
    logic [2:0] funct3;                   // Minor opcode
    logic       alt;                      // funct7 bit 5
    logic       sub_en;                   // SUB only valid in OP
    alu_op_t    arith_op;                 // Shared OP/OP-IMM result
    alu_op_t    cmp_op;                   // Branch compare op

    assign opcode = instr_i.r_view.opcode;
    assign funct3 = instr_i.r_view.funct3;
    assign alt    = instr_i.r_view.funct7[5];
    assign sub_en = (opcode == OP_REG) && alt;  // ADDI has no SUBI

    // ========================================
    // Arithmetic funct3 table
    // ========================================

    always_comb begin
        case (funct3)
            3'b000:  arith_op = sub_en ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;  // Both OP and OP-IMM
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    // Branch compare, EQ/NE by subtract
    always_comb begin
        case (funct3)
            3'b000, 3'b001: cmp_op = ALU_SUB;     // BEQ, BNE
            3'b100, 3'b101: cmp_op = ALU_SLT;     // BLT, BGE
            3'b110, 3'b111: cmp_op = ALU_SLTU;    // BLTU, BGEU
            default:        cmp_op = ALU_SUB;     // Reserved codes
        endcase
    end

    // ========================================
    // Per-opcode control
    // ========================================

    always_comb begin
        ctrl_o             = '0;           // Enables off, reg source
        ctrl_o.alu_op      = ALU_ADD;
        ctrl_o.mem_size    = MEM_W;

        case (opcode)
            OP_LUI: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_op    = ALU_LUI;   // Pass the U immediate
                ctrl_o.alu_src   = 1'b1;
            end
            OP_AUIPC: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;      // PC + imm in execute
            end
            OP_JAL: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.jump      = 1'b1;
            end
            OP_JALR: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_op    = ALU_COPY;
                ctrl_o.jump      = 1'b1;      // Target formed in execute
            end
            OP_BRANCH: begin
                ctrl_o.branch      = 1'b1;
                ctrl_o.branch_type = funct3;
                ctrl_o.alu_op      = cmp_op;  // rs1 vs rs2
            end
            OP_LOAD: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.mem_read  = 1'b1;
                ctrl_o.alu_src   = 1'b1;      // Address = rs1 + imm
                case (funct3)
                    3'b000:  ctrl_o.mem_size = MEM_B;   // LB
                    3'b001:  ctrl_o.mem_size = MEM_H;   // LH
                    3'b100:  ctrl_o.mem_size = MEM_BU;  // LBU
                    3'b101:  ctrl_o.mem_size = MEM_HU;  // LHU
                    default: ctrl_o.mem_size = MEM_W;   // LW and illegal
                endcase
            end
            OP_STORE: begin
                ctrl_o.mem_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                case (funct3)
                    3'b000:  ctrl_o.mem_size = MEM_B;   // SB
                    3'b001:  ctrl_o.mem_size = MEM_H;   // SH
                    default: ctrl_o.mem_size = MEM_W;   // SW and illegal
                endcase
            end
            OP_IMM: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.alu_op    = arith_op;
            end
            OP_REG: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_op    = arith_op;
            end
            default: begin
                ctrl_o.alu_op    = ALU_ADD;   // Unknown acts as a NOP
            end
        endcase
    end

endmodule

//--- verilog/decode_pipe_reg.sv
`timescale 1ns/1ps

module decode_pipe_reg (
    input  logic                 clk_i,    // Core clock
    input  logic                 rst_i,    // Sync reset, active high
    input  logic                 stall_i,  // Hold current contents
    input  decode_pkg::dec_out_t d_i,      // Next decode bundle
    output decode_pkg::dec_out_t q_o       // Registered bundle to execute
);

    // ========================================
    // Decode/execute register
    // ========================================

    // Zero also gives ALU_ADD and mem_size 000
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;                   // One-cycle latency
        end
    end

    // ========================================
    // Checks
    // ========================================

    // A stalled edge must not disturb execute's view
    a_stall_hold: assert property (
        @(posedge clk_i) disable iff (rst_i)
        stall_i |=> $stable(q_o)
    ) else $error("decode register changed across a stall");

    // Decoder must not mark one instruction as both load and store
    a_mem_excl: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(q_o.ctrl.mem_read && q_o.ctrl.mem_write)
    ) else $error("mem_read and mem_write both set");

    // Branch and jump are separate opcodes
    a_flow_excl: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(q_o.ctrl.branch && q_o.ctrl.jump)
    ) else $error("branch and jump both set");

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                                   clk_i,          // Core clock
    input  logic                                   rst_i,          // Sync reset
    input  logic [riscv_isa_pkg::XLEN-1:0]         pc_i,           // From fetch
    input  logic [riscv_isa_pkg::XLEN-1:0]         instr_i,        // From fetch
    input  logic                                   instr_valid_i,  // Fetch valid
    input  logic                                   stall_i,        // Level hold
    input  logic [riscv_isa_pkg::XLEN-1:0]         rs1_data_i,     // Regfile port a
    input  logic [riscv_isa_pkg::XLEN-1:0]         rs2_data_i,     // Regfile port b
    output logic [riscv_isa_pkg::REG_ADDR_W-1:0]   rs1_addr_o,     // Regfile port a addr
    output logic [riscv_isa_pkg::REG_ADDR_W-1:0]   rs2_addr_o,     // Regfile port b addr
    output decode_pkg::dec_out_t                   dec_o           // To execute
);

    import riscv_isa_pkg::*;
    import decode_pkg::*;

    instr_word_u          instr_w;        // Union view of instr_i
    logic [XLEN-1:0]      imm;            // From imm_gen
    ctrl_t                ctrl;           // From ctrl_decoder
    dec_out_t             dec_next;       // Register input

    // ========================================
    // Field extraction
    // ========================================

    assign instr_w = instr_i;

    // Same-cycle read, data comes back before the edge
    assign rs1_addr_o = instr_w.r_view.rs1;
    assign rs2_addr_o = instr_w.r_view.rs2;

    // ========================================
    // Decoders
    // ========================================

    imm_gen u_imm_gen (
        .instr_i (instr_w),
        .imm_o   (imm)
    );

    ctrl_decoder u_ctrl_decoder (
        .instr_i (instr_w),
        .ctrl_o  (ctrl)
    );

    // Control decoded regardless of valid
    always_comb begin
        dec_next.valid    = instr_valid_i;
        dec_next.pc       = pc_i;
        dec_next.rd       = instr_w.r_view.rd;
        dec_next.rs1_data = rs1_data_i;
        dec_next.rs2_data = rs2_data_i;
        dec_next.imm      = imm;
        dec_next.ctrl     = ctrl;
    end

    // ========================================
    // Pipeline register
    // ========================================

    decode_pipe_reg u_pipe_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .stall_i (stall_i),
        .d_i     (dec_next),
        .q_o     (dec_o)
    );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40          // Full clock period
) (
    output logic clk_o                    // Free-running testbench clock
);

    // ========================================
    // Clock source
    // ========================================

    initial begin
        clk_o = 1'b0;                     // Known level at time zero
    end

    always begin
        #(PERIOD_NS / 2) clk_o = ~clk_o;  // 50% duty
    end

endmodule

//--- sim/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// ========================================
// Immediate from the ISA spec encodings
// ========================================

function automatic logic [31:0] build_immediate(input logic [31:0] w);
    logic [31:0] imm;
    case (w[6:0])
        7'b0110111, 7'b0010111: imm = {w[31:12], 12'b0};                  // LUI, AUIPC
        7'b1101111: imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};  // JAL
        7'b1100011: imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};    // Branch
        7'b0100011: imm = {{20{w[31]}}, w[31:25], w[11:7]};               // Store
        7'b0110011: imm = 32'h0;                                          // OP has no imm
        default:    imm = {{20{w[31]}}, w[31:20]};                        // I and unknown
    endcase
    return imm;
endfunction

// ========================================
// Control rules
// ========================================

// ALU function for OP and OP-IMM
function automatic alu_op_t alu_for_funct3(input logic [2:0] f3, input logic f7b5,
                                           input logic is_reg);
    alu_op_t op;
    case (f3)
        3'b000: op = (is_reg && f7b5) ? ALU_SUB : ALU_ADD;   // No SUBI
        3'b001: op = ALU_SLL;
        3'b010: op = ALU_SLT;
        3'b011: op = ALU_SLTU;
        3'b100: op = ALU_XOR;
        3'b101: op = f7b5 ? ALU_SRA : ALU_SRL;
        3'b110: op = ALU_OR;
        default: op = ALU_AND;
    endcase
    return op;
endfunction

function automatic ctrl_t decode_control(input logic [31:0] w);
    ctrl_t       c;
    logic [2:0]  f3;
    f3         = w[14:12];
    c          = '0;                      // All enables low
    c.alu_op   = ALU_ADD;
    c.mem_size = MEM_W;
    case (w[6:0])
        7'b0110111: begin                 // LUI
            c.reg_write = 1'b1;
            c.alu_src   = 1'b1;
            c.alu_op    = ALU_LUI;
        end
        7'b0010111: begin                 // AUIPC
            c.reg_write = 1'b1;
            c.alu_src   = 1'b1;
        end
        7'b1101111: begin                 // JAL
            c.reg_write = 1'b1;
            c.alu_src   = 1'b1;
            c.jump      = 1'b1;
        end
        7'b1100111: begin                 // JALR
            c.reg_write = 1'b1;
            c.jump      = 1'b1;
            c.alu_op    = ALU_COPY;
        end
        7'b1100011: begin
            c.branch      = 1'b1;
            c.branch_type = f3;
            c.alu_op      = !f3[2] ? ALU_SUB : (f3[1] ? ALU_SLTU : ALU_SLT);
        end
        7'b0000011: begin
            c.reg_write = 1'b1;
            c.mem_read  = 1'b1;
            c.alu_src   = 1'b1;
            if (f3 != 3'b011 && f3 != 3'b110 && f3 != 3'b111) c.mem_size = mem_size_t'(f3);
        end
        7'b0100011: begin
            c.mem_write = 1'b1;
            c.alu_src   = 1'b1;
            if (f3 <= 3'b010) c.mem_size = mem_size_t'(f3);   // SB, SH, SW
        end
        7'b0010011: begin
            c.reg_write = 1'b1;
            c.alu_src   = 1'b1;
            c.alu_op    = alu_for_funct3(f3, w[30], 1'b0);
        end
        7'b0110011: begin
            c.reg_write = 1'b1;
            c.alu_op    = alu_for_funct3(f3, w[30], 1'b1);
        end
        default: ;                        // Unknown keeps defaults
    endcase
    return c;
endfunction

// Whole bundle that execute should see after one edge
function automatic dec_out_t next_bundle(input logic v, input logic [31:0] pc,
                                         input logic [31:0] w, input logic [31:0] d1,
                                         input logic [31:0] d2);
    dec_out_t b;
    b.valid    = v;
    b.pc       = pc;
    b.rd       = w[11:7];
    b.rs1_data = d1;
    b.rs2_data = d2;
    b.imm      = build_immediate(w);
    b.ctrl     = decode_control(w);
    return b;
endfunction

`endif

//--- sim/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;

    import decode_pkg::*;

    `include "decode_model.svh"

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_RANDOM   = 500;
    localparam int NUM_DIRECTED = 14;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + NUM_RANDOM + NUM_DIRECTED;
    localparam int DRIVE_DELAY  = 2;      // ns after rising edge

    logic        clk;
    logic        rst;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        instr_valid;
    logic        stall;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    dec_out_t    dec;
    dec_out_t    exp_q;                   // Scoreboard copy of dec_o
    integer      seed = 68;
    int          errors = 0;
    int          checks = 0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clk_o(clk));

    decode_stage uut (
        .clk_i         (clk),
        .rst_i         (rst),
        .pc_i          (pc),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .stall_i       (stall),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .dec_o         (dec)
    );

    // ========================================
    // Checking helpers
    // ========================================

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] e, input logic [31:0] a);
        errors++;
        $display("mismatch %s %s: expected %h actual %h", name, field, e, a);
    endtask

    task automatic compare_bundle(input string name, input dec_out_t e, input dec_out_t a);
        checks++;
        if (a.valid !== e.valid) report_mismatch(name, "valid", e.valid, a.valid);
        if (a.pc !== e.pc) report_mismatch(name, "pc", e.pc, a.pc);
        if (a.rd !== e.rd) report_mismatch(name, "rd", e.rd, a.rd);
        if (a.rs1_data !== e.rs1_data) report_mismatch(name, "rs1_data", e.rs1_data, a.rs1_data);
        if (a.rs2_data !== e.rs2_data) report_mismatch(name, "rs2_data", e.rs2_data, a.rs2_data);
        if (a.imm !== e.imm) report_mismatch(name, "imm", e.imm, a.imm);
        if (a.ctrl !== e.ctrl) report_mismatch(name, "ctrl", e.ctrl, a.ctrl);
    endtask

    // One cycle of drive, address check, clock edge and bundle compare
    task automatic step(input string name, input logic [31:0] word, input logic st);
        logic [31:0] pc_v;
        logic [31:0] d1;
        logic [31:0] d2;
        logic        v;
        pc_v = $random(seed);
        d1   = $random(seed);
        d2   = $random(seed);
        v    = $random(seed);
        pc          = pc_v;
        instr       = word;
        instr_valid = v;
        stall       = st;
        rs1_data    = d1;
        rs2_data    = d2;
        #1;                                   // Let the address path settle
        checks++;
        if (rs1_addr !== word[19:15]) report_mismatch(name, "rs1_addr", word[19:15], rs1_addr);
        if (rs2_addr !== word[24:20]) report_mismatch(name, "rs2_addr", word[24:20], rs2_addr);
        if (!st) exp_q = next_bundle(v, pc_v, word, d1, d2);   // Stall holds scoreboard
        @(posedge clk);
        #DRIVE_DELAY;
        compare_bundle(name, exp_q, dec);
    endtask

    // Random word with mostly kept opcodes
    task automatic random_word(output logic [31:0] w);
        logic [31:0] r;
        logic [6:0]  op;
        r = $random(seed);
        case ({$random(seed)} % 10)
            0: op = 7'b0110111;               // LUI
            1: op = 7'b0010111;               // AUIPC
            2: op = 7'b1101111;               // JAL
            3: op = 7'b1100111;               // JALR
            4: op = 7'b1100011;               // Branch
            5: op = 7'b0000011;               // Load
            6: op = 7'b0100011;               // Store
            7: op = 7'b0010011;               // OP-IMM
            8: op = 7'b0110011;               // OP
            default: op = $random(seed);      // Any code and often unknown
        endcase
        w = {r[31:7], op};
    endtask

    // Directed word with literal imm and ALU op
    task automatic run_directed(input string name, input logic [31:0] word,
                                input logic [31:0] exp_imm, input alu_op_t exp_alu,
                                input logic unknown);
        ctrl_t dflt;
        dflt          = '0;
        dflt.alu_op   = ALU_ADD;
        dflt.mem_size = MEM_W;
        step(name, word, 1'b0);
        if (dec.imm !== exp_imm) report_mismatch(name, "literal imm", exp_imm, dec.imm);
        if (dec.ctrl.alu_op !== exp_alu) report_mismatch(name, "alu_op", exp_alu, dec.ctrl.alu_op);
        if (unknown && dec.ctrl !== dflt) report_mismatch(name, "default ctrl", dflt, dec.ctrl);
    endtask

    // ========================================
    // Stimulus
    // ========================================

    initial begin
        logic [31:0] w;
        rst         = 1'b1;
        stall       = 1'b0;
        instr_valid = 1'b0;
        pc          = '0;
        instr       = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        exp_q       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        compare_bundle("after_reset", '0, dec);           // Cleared before any load
        random_word(w);
        step("reset_stalled", w, 1'b1);                    // Still zero through a stall

        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_word(w);
            step("random", w, ({$random(seed)} % 4) == 0);  // Stall about 1 in 4
        end

        run_directed("i_all_ones", 32'hFFF10093, 32'hFFFFFFFF, ALU_ADD, 1'b0);
        run_directed("s_all_ones", 32'hFE002FA3, 32'hFFFFFFFF, ALU_ADD, 1'b0);
        run_directed("b_all_ones", 32'hFE000FE3, 32'hFFFFFFFE, ALU_SUB, 1'b0);
        run_directed("u_all_ones", 32'hFFFFF037, 32'hFFFFF000, ALU_LUI, 1'b0);
        run_directed("j_all_ones", 32'hFFFFF06F, 32'hFFFFFFFE, ALU_ADD, 1'b0);
        run_directed("b_minus_8", 32'hFE000CE3, 32'hFFFFFFF8, ALU_SUB, 1'b0);
        run_directed("j_minus_16", 32'hFF1FF06F, 32'hFFFFFFF0, ALU_ADD, 1'b0);
        run_directed("srai", 32'h40315093, 32'h00000403, ALU_SRA, 1'b0);
        run_directed("srli", 32'h00315093, 32'h00000003, ALU_SRL, 1'b0);
        run_directed("sub", 32'h402081B3, 32'h00000000, ALU_SUB, 1'b0);
        run_directed("add", 32'h002081B3, 32'h00000000, ALU_ADD, 1'b0);
        run_directed("addi_bit30", 32'h40000093, 32'h00000400, ALU_ADD, 1'b0);  // No SUBI
        run_directed("unknown_7f", 32'hFFF0007F, 32'hFFFFFFFF, ALU_ADD, 1'b1);
        run_directed("unknown_0b", 32'h8000000B, 32'hFFFFF800, ALU_ADD, 1'b1);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // ========================================
    // Watchdog
    // ========================================

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD * 2);
        $display("watchdog expired before the tests finished, errors so far %0d", errors);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- all.f
+incdir+sim
verilog/riscv_isa_pkg.sv
verilog/decode_pkg.sv
verilog/imm_gen.sv
verilog/ctrl_decoder.sv
verilog/decode_pipe_reg.sv
verilog/decode_stage.sv
sim/tb_clock_gen.sv
sim/tb_decode_stage.sv
